// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth = 32;
    localparam logic [dataWidth-1:0] resetPc = '0;
    localparam int mulLatency = 32;
    localparam int mulCountWidth = $clog2(mulLatency + 1);

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // function field under SPECIAL
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;

    typedef logic [4:0] regAddr_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui,
        aluPassB
    } aluOp_e;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   branch;
        logic   branchNe;  // inverts the equality test
        logic   jump;
        logic   mulStart;
        logic   hiloRead;
        logic   hiloSelHi;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;  // low for a bubble
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] pc;
    } fetchDecPayload_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] regA;
        logic [dataWidth-1:0] regB;
        logic [dataWidth-1:0] imm;
        regAddr_t             rs;
        regAddr_t             rt;
        regAddr_t             destReg;
        logic [4:0]           shamt;
        logic [25:0]          jumpIdx;  // instr_index field of j
    } decExPayload_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
        regAddr_t             destReg;
    } exMemPayload_t;

    typedef struct packed {
        logic                 regWrite;
        logic                 memToReg;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] loadData;
        regAddr_t             destReg;
    } memWbPayload_t;

    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [dataWidth-1:0] addr;  // word aligned
        logic [dataWidth-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic                 valid;
        regAddr_t             regNum;
        logic [dataWidth-1:0] data;
    } wbInfo_t;

endpackage

// ==== pipeReg.sv ====
`timescale 1ns/1ns

module pipeReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  bit       stall,
    input  bit       flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;  // zero payload is a bubble
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic                         clk,
    input  bit                           writeEnable,
    input  cpuPkg::regAddr_t             readAddrA,
    input  cpuPkg::regAddr_t             readAddrB,
    input  cpuPkg::regAddr_t             writeAddr,
    input  logic [cpuPkg::dataWidth-1:0] writeData,
    output logic [cpuPkg::dataWidth-1:0] readDataA,
    output logic [cpuPkg::dataWidth-1:0] readDataB
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    function automatic logic [dataWidth-1:0] readPort(input regAddr_t addr,
                                                      input logic [dataWidth-1:0] stored);
        if (addr == '0)
            return '0;
        if (writeEnable && writeAddr == addr)
            return writeData;  // same-cycle writeback wins
        return stored;
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA, regs[readAddrA]);
        readDataB = readPort(readAddrB, regs[readAddrB]);
    end

endmodule

// ==== mainDecoder.sv ====
`timescale 1ns/1ns

module mainDecoder (
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output cpuPkg::ctrl_t                ctrl,
    output cpuPkg::regAddr_t             rs,
    output cpuPkg::regAddr_t             rt,
    output cpuPkg::regAddr_t             destReg,
    output logic [cpuPkg::dataWidth-1:0] imm,
    output logic [4:0]                   shamt
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       useRd;  // R-type result goes to rd

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign shamt   = instr[10:6];
    assign destReg = useRd ? instr[15:11] : rt;

    // ori is the only zero-extended immediate here
    assign imm = (opcode == opOri) ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        useRd      = 1'b0;
        case (opcode)
            opSpecial: begin
                useRd         = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSll:   ctrl.aluOp = aluSll;
                    fnMfhi: begin
                        ctrl.hiloRead  = 1'b1;
                        ctrl.hiloSelHi = 1'b1;
                    end
                    fnMflo:  ctrl.hiloRead = 1'b1;
                    fnMultu: begin
                        ctrl.regWrite = 1'b0;  // result lands in hi/lo
                        ctrl.mulStart = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;  // unsupported function
                endcase
            end
            opAddiu: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOr;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluLui;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opJ:     ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
    input  cpuPkg::aluOp_e               op,
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  logic [4:0]                   shamt,
    output logic [cpuPkg::dataWidth-1:0] result,
    output bit                           equal
);
    import cpuPkg::*;

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;

    assign sum   = a + b;
    assign diff  = a - b;
    assign equal = (a == b);  // beq/bne decision

    always_comb begin
        result = '0;
        case (op)
            aluAdd: result = sum;
            aluSub: result = diff;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluSlt: result[0] = $signed(a) < $signed(b);
            aluSll: result = b << shamt;  // sll shifts rt
            aluLui: result = {b[15:0], 16'b0};
            default: result = b;  // passB and spare codes
        endcase
    end

endmodule

// ==== mulDivUnit.sv ====
`timescale 1ns/1ns

module mulDivUnit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    output bit                           busy,
    output logic [cpuPkg::dataWidth-1:0] hi,
    output logic [cpuPkg::dataWidth-1:0] lo
);
    import cpuPkg::*;

    logic [mulCountWidth-1:0] count;  // iterations left
    logic [dataWidth-1:0]     mcand;
    logic [dataWidth:0]       partial;

    assign busy = (count != '0);

    // lo starts as the multiplier and is shifted out one bit per step
    assign partial = {1'b0, hi} + (lo[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= mulCountWidth'(mulLatency);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a;
            hi    <= '0;
            lo    <= b;
        end else if (busy) begin
            {hi, lo} <= {partial, lo[dataWidth-1:1]};  // add then shift right
        end
    end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
    input  cpuPkg::regAddr_t rsE,
    input  cpuPkg::regAddr_t rtE,
    input  logic             memReadE,
    input  cpuPkg::regAddr_t destRegM,
    input  logic             regWriteM,
    input  logic             memReadM,
    input  cpuPkg::regAddr_t destRegW,
    input  logic             regWriteW,
    input  cpuPkg::regAddr_t rsD,
    input  cpuPkg::regAddr_t rtD,
    input  logic             branchTakenE,
    input  logic             mulBusy,
    output logic             stallF,
    output logic             stallD,
    output logic             stallE,
    output logic             flushD,
    output logic             flushE,
    output logic             flushM,
    output logic [1:0]       forwardAE,
    output logic [1:0]       forwardBE
);
    import cpuPkg::*;

    logic loadUse;

    // 10 memory, 01 writeback, 00 register file
    function automatic logic [1:0] forwardSel(input regAddr_t src);
        if (src == '0)
            return 2'b00;
        if (regWriteM && !memReadM && destRegM == src)
            return 2'b10;  // load data only exists from writeback
        if (regWriteW && destRegW == src)
            return 2'b01;
        return 2'b00;
    endfunction

    always_comb begin
        forwardAE = forwardSel(rsE);
        forwardBE = forwardSel(rtE);
    end

    assign loadUse = memReadE && (rtE == rsD || rtE == rtD);

    // a busy multiplier freezes the front end and holds back a pending redirect
    assign stallF = loadUse || mulBusy;
    assign stallD = loadUse || mulBusy;
    assign stallE = mulBusy;
    assign flushD = branchTakenE && !mulBusy;
    assign flushE = (loadUse || branchTakenE) && !mulBusy;
    assign flushM = mulBusy;

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ns

module datapath (
    input  logic                         clk,
    input  logic                         reset,
    output logic [cpuPkg::dataWidth-1:0] pcF,
    input  logic [cpuPkg::dataWidth-1:0] instrF,
    output cpuPkg::memReq_t              memReq,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    output cpuPkg::wbInfo_t              retire
);
    import cpuPkg::*;

    logic                 stallF, stallD, stallE;
    logic                 flushD, flushE, flushM;
    logic [1:0]           forwardAE, forwardBE;
    logic                 branchTakenE, mulBusy;
    logic [dataWidth-1:0] pcPlus4F, pcNext;

    fetchDecPayload_t     fetchDecD, fetchDecQ;
    ctrl_t                ctrlRawD, ctrlD;
    regAddr_t             rsD, rtD, destRegD;
    logic [dataWidth-1:0] immD, regAD, regBD;
    logic [4:0]           shamtD;

    decExPayload_t        decExD, decExIn, decExQ;
    logic [dataWidth-1:0] fwdAE, fwdBE, srcBE, aluResultE, resultE;
    logic [dataWidth-1:0] pcPlus4E, branchTargetE, jumpTargetE, hi, lo;
    logic                 equalE;

    exMemPayload_t        exMemD, exMemQ;
    memWbPayload_t        memWbD, memWbQ;
    logic [dataWidth-1:0] resultW;

    function automatic logic [dataWidth-1:0] fwdMux(input logic [1:0] sel,
                                                    input logic [dataWidth-1:0] regVal,
                                                    input logic [dataWidth-1:0] memVal,
                                                    input logic [dataWidth-1:0] wbVal);
        case (sel)
            2'b10:   return memVal;
            2'b01:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pcF + 32'd4;
    assign pcNext   = !branchTakenE ? pcPlus4F :
                      decExQ.ctrl.jump ? jumpTargetE : branchTargetE;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= resetPc;
        end else if (!stallF) begin
            pcF <= pcNext;
        end
    end

    assign fetchDecD = '{valid: 1'b1, instr: instrF, pc: pcF};

    pipeReg #(.payload_t(fetchDecPayload_t)) decReg (
        .clk(clk), .reset(reset), .stall(stallD), .flush(flushD),
        .d(fetchDecD), .q(fetchDecQ));

    // decode
    mainDecoder dec0 (
        .instr(fetchDecQ.instr), .ctrl(ctrlRawD), .rs(rsD), .rt(rtD),
        .destReg(destRegD), .imm(immD), .shamt(shamtD));

    assign ctrlD = fetchDecQ.valid ? ctrlRawD : '0;  // bubbles carry no control

    regFile rf0 (
        .clk(clk), .writeEnable(memWbQ.regWrite), .readAddrA(rsD), .readAddrB(rtD),
        .writeAddr(memWbQ.destReg), .writeData(resultW),
        .readDataA(regAD), .readDataB(regBD));

    assign decExD = '{ctrl: ctrlD, pc: fetchDecQ.pc, regA: regAD, regB: regBD, imm: immD,
                      rs: rsD, rt: rtD, destReg: destRegD, shamt: shamtD,
                      jumpIdx: fetchDecQ.instr[25:0]};

    // a held instruction recirculates with its operands already forwarded,
    // since the producers drain out of M and W while it waits
    always_comb begin
        decExIn = decExD;
        if (stallE) begin
            decExIn      = decExQ;
            decExIn.regA = fwdAE;
            decExIn.regB = fwdBE;
        end
    end

    pipeReg #(.payload_t(decExPayload_t)) exReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushE),
        .d(decExIn), .q(decExQ));

    // execute
    assign fwdAE = fwdMux(forwardAE, decExQ.regA, exMemQ.aluResult, resultW);
    assign fwdBE = fwdMux(forwardBE, decExQ.regB, exMemQ.aluResult, resultW);
    assign srcBE = decExQ.ctrl.aluSrcImm ? decExQ.imm : fwdBE;

    alu alu0 (
        .op(decExQ.ctrl.aluOp), .a(fwdAE), .b(srcBE), .shamt(decExQ.shamt),
        .result(aluResultE), .equal(equalE));

    mulDivUnit mul0 (
        .clk(clk), .reset(reset), .start(decExQ.ctrl.mulStart && !mulBusy),
        .a(fwdAE), .b(fwdBE), .busy(mulBusy), .hi(hi), .lo(lo));

    assign resultE = !decExQ.ctrl.hiloRead ? aluResultE :
                     decExQ.ctrl.hiloSelHi ? hi : lo;

    assign pcPlus4E      = decExQ.pc + 32'd4;
    assign branchTargetE = pcPlus4E + {decExQ.imm[29:0], 2'b00};
    assign jumpTargetE   = {pcPlus4E[31:28], decExQ.jumpIdx, 2'b00};
    assign branchTakenE  = decExQ.ctrl.jump ||
                           (decExQ.ctrl.branch && (equalE != decExQ.ctrl.branchNe));

    hazardUnit haz0 (
        .rsE(decExQ.rs), .rtE(decExQ.rt), .memReadE(decExQ.ctrl.memRead),
        .destRegM(exMemQ.destReg), .regWriteM(exMemQ.ctrl.regWrite),
        .memReadM(exMemQ.ctrl.memRead),
        .destRegW(memWbQ.destReg), .regWriteW(memWbQ.regWrite),
        .rsD(rsD), .rtD(rtD), .branchTakenE(branchTakenE), .mulBusy(mulBusy),
        .stallF(stallF), .stallD(stallD), .stallE(stallE),
        .flushD(flushD), .flushE(flushE), .flushM(flushM),
        .forwardAE(forwardAE), .forwardBE(forwardBE));

    assign exMemD = '{ctrl: decExQ.ctrl, aluResult: resultE, storeData: fwdBE,
                      destReg: decExQ.destReg};

    pipeReg #(.payload_t(exMemPayload_t)) memReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushM),
        .d(exMemD), .q(exMemQ));

    // memory
    assign memReq = '{read: exMemQ.ctrl.memRead, write: exMemQ.ctrl.memWrite,
                      addr: {exMemQ.aluResult[31:2], 2'b00}, wdata: exMemQ.storeData};

    assign memWbD = '{regWrite: exMemQ.ctrl.regWrite, memToReg: exMemQ.ctrl.memToReg,
                      aluResult: exMemQ.aluResult, loadData: memRdata,
                      destReg: exMemQ.destReg};

    pipeReg #(.payload_t(memWbPayload_t)) wbReg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .d(memWbD), .q(memWbQ));

    // writeback
    assign resultW = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;
    assign retire  = '{valid: memWbQ.regWrite, regNum: memWbQ.destReg, data: resultW};

endmodule

// ==== tbDatapath.sv ====
`timescale 1ns/1ns

module tbDatapath;
    import cpuPkg::*;

    typedef struct packed {
        logic    isStore;
        wbInfo_t ret;
        memReq_t st;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic [dataWidth-1:0] pcF;
    logic [dataWidth-1:0] instrF;
    memReq_t              memReq;
    logic [dataWidth-1:0] memRdata;
    wbInfo_t              retire;

    logic [dataWidth-1:0] progMem [64];
    logic [dataWidth-1:0] dataMem [64];
    expect_t              expectQ [$];
    wbInfo_t              retireQ [$];  // filled by the monitor
    memReq_t              storeQ [$];
    int                   cycleCount = 0;  // cycles since reset release
    int                   valueErrors = 0;
    int                   timeouts = 0;
    int                   otherErrors = 0;

    datapath dut0 (
        .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF),
        .memReq(memReq), .memRdata(memRdata), .retire(retire));

    always #20 clk = ~clk;

    function automatic logic [31:0] rTypeWord(input logic [5:0] fn, input regAddr_t rs,
                                              input regAddr_t rt, input regAddr_t rd,
                                              input logic [4:0] sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [5:0] op, input regAddr_t rs,
                                              input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jTypeWord(input logic [25:0] idx);
        return {opJ, idx};
    endfunction

    function automatic expect_t retireEntry(input regAddr_t r, input logic [31:0] d);
        expect_t e;
        e = '0;
        e.ret = '{valid: 1'b1, regNum: r, data: d};
        return e;
    endfunction

    function automatic expect_t storeEntry(input logic [31:0] a, input logic [31:0] d);
        expect_t e;
        e = '0;
        e.isStore = 1'b1;
        e.st = '{read: 1'b0, write: 1'b1, addr: a, wdata: d};
        return e;
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            progMem[i] = '0;
            dataMem[i] = {16'hDEAD, 8'h00, i[5:0], 2'b00};  // fill tagged by word address
        end
        progMem[0]  = iTypeWord(opLui, 5'd0, 5'd1, 16'h1234);
        progMem[1]  = iTypeWord(opOri, 5'd1, 5'd1, 16'h5678);     // $1 from memory stage
        progMem[2]  = iTypeWord(opAddiu, 5'd0, 5'd2, 16'd5);
        progMem[3]  = rTypeWord(fnAddu, 5'd1, 5'd2, 5'd3, 5'd0);   // $1 from writeback
        progMem[4]  = rTypeWord(fnSubu, 5'd3, 5'd2, 5'd4, 5'd0);
        progMem[5]  = iTypeWord(opAddiu, 5'd0, 5'd6, 16'hFFFD);
        progMem[6]  = rTypeWord(fnSlt, 5'd6, 5'd2, 5'd7, 5'd0);    // signed compare
        progMem[7]  = rTypeWord(fnSll, 5'd0, 5'd2, 5'd8, 5'd4);
        progMem[8]  = rTypeWord(fnOr, 5'd8, 5'd7, 5'd9, 5'd0);
        progMem[9]  = rTypeWord(fnAnd, 5'd9, 5'd1, 5'd10, 5'd0);
        progMem[10] = iTypeWord(opSw, 5'd8, 5'd4, 16'h0010);
        progMem[11] = iTypeWord(opLw, 5'd8, 5'd11, 16'h0010);
        progMem[12] = rTypeWord(fnAddu, 5'd11, 5'd2, 5'd12, 5'd0); // load-use
        progMem[13] = iTypeWord(opBeq, 5'd12, 5'd3, 16'd2);        // taken to 16
        progMem[14] = iTypeWord(opAddiu, 5'd0, 5'd13, 16'd1);
        progMem[15] = iTypeWord(opAddiu, 5'd0, 5'd13, 16'd2);
        progMem[16] = iTypeWord(opBne, 5'd12, 5'd3, 16'd2);        // falls through
        progMem[17] = iTypeWord(opAddiu, 5'd0, 5'd14, 16'h0077);
        progMem[18] = jTypeWord(26'd20);
        progMem[19] = iTypeWord(opAddiu, 5'd0, 5'd14, 16'h0099);
        progMem[20] = iTypeWord(opLui, 5'd0, 5'd15, 16'h0001);
        progMem[21] = iTypeWord(opOri, 5'd15, 5'd15, 16'h0001);
        progMem[22] = rTypeWord(fnMultu, 5'd6, 5'd15, 5'd0, 5'd0);
        progMem[23] = rTypeWord(fnMfhi, 5'd0, 5'd0, 5'd16, 5'd0);
        progMem[24] = rTypeWord(fnMflo, 5'd0, 5'd0, 5'd17, 5'd0);
        progMem[25] = iTypeWord(opAddiu, 5'd0, 5'd0, 16'h0055);    // write to $0
        progMem[26] = rTypeWord(fnAddu, 5'd0, 5'd0, 5'd18, 5'd0);
        progMem[27] = iTypeWord(opOri, 5'd0, 5'd19, 16'h0F00);
        progMem[28] = iTypeWord(opSw, 5'd0, 5'd17, 16'h0020);
        progMem[29] = jTypeWord(26'd29);                            // park here
    endtask

    task automatic loadExpected();
        expectQ.push_back(retireEntry(5'd1, 32'h1234_0000));
        expectQ.push_back(retireEntry(5'd1, 32'h1234_5678));
        expectQ.push_back(retireEntry(5'd2, 32'h0000_0005));
        expectQ.push_back(retireEntry(5'd3, 32'h1234_567D));
        expectQ.push_back(retireEntry(5'd4, 32'h1234_5678));
        expectQ.push_back(retireEntry(5'd6, 32'hFFFF_FFFD));
        expectQ.push_back(retireEntry(5'd7, 32'h0000_0001));
        expectQ.push_back(retireEntry(5'd8, 32'h0000_0050));
        expectQ.push_back(retireEntry(5'd9, 32'h0000_0051));
        expectQ.push_back(retireEntry(5'd10, 32'h0000_0050));
        expectQ.push_back(storeEntry(32'h0000_0060, 32'h1234_5678));
        expectQ.push_back(retireEntry(5'd11, 32'h1234_5678));
        expectQ.push_back(retireEntry(5'd12, 32'h1234_567D));
        expectQ.push_back(retireEntry(5'd14, 32'h0000_0077));
        expectQ.push_back(retireEntry(5'd15, 32'h0001_0000));
        expectQ.push_back(retireEntry(5'd15, 32'h0001_0001));
        expectQ.push_back(retireEntry(5'd16, 32'h0001_0000));     // 0xFFFFFFFD * 0x10001
        expectQ.push_back(retireEntry(5'd17, 32'hFFFC_FFFD));
        expectQ.push_back(retireEntry(5'd0, 32'h0000_0055));
        expectQ.push_back(retireEntry(5'd18, 32'h0000_0000));
        expectQ.push_back(retireEntry(5'd19, 32'h0000_0F00));
        expectQ.push_back(storeEntry(32'h0000_0020, 32'hFFFC_FFFD));
    endtask

    task automatic checkRetire(input wbInfo_t expected, input wbInfo_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED %0t ns: retire expected v=%0b r%0d=%h, actual v=%0b r%0d=%h",
                     $time, expected.valid, expected.regNum, expected.data,
                     actual.valid, actual.regNum, actual.data);
        end
    endtask

    task automatic checkStore(input memReq_t expected, input memReq_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED %0t ns: memReq expected r%0b w%0b %h=%h, actual r%0b w%0b %h=%h",
                     $time, expected.read, expected.write, expected.addr, expected.wdata,
                     actual.read, actual.write, actual.addr, actual.wdata);
        end
    endtask

    task automatic checkPc(input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED %0t ns: pcF expected %h, actual %h", $time, expected, actual);
        end
    endtask

    task automatic waitForEvent(input bit isStore, output bit got);
        int cycles;
        cycles = 0;
        while ((isStore ? storeQ.size() : retireQ.size()) == 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        got = (isStore ? storeQ.size() : retireQ.size()) != 0;
        if (!got) begin
            timeouts++;
            $display("timeout at %0t ns: no %s seen within 200 cycles", $time,
                     isStore ? "store" : "retire");
        end
    endtask

    // memories answer 2 ns after each edge, once pcF and memReq have settled
    always @(posedge clk) begin
        #2;
        if (memReq.write)
            dataMem[memReq.addr[7:2]] = memReq.wdata;
        instrF   = progMem[pcF[7:2]];
        memRdata = memReq.read ? dataMem[memReq.addr[7:2]] : '0;  // data only on a read
    end

    always @(negedge clk) begin
        if (reset)
            cycleCount = 0;
        else
            cycleCount++;
        if (cycleCount == 1)
            checkPc(resetPc, pcF);  // first fetch
        if (retire.valid) begin
            if (cycleCount < 5) begin
                otherErrors++;
                $display("retire strobe at %0t ns before the first instruction could retire",
                         $time);
            end
            retireQ.push_back(retire);
        end
        if ((memReq.read || memReq.write) && cycleCount < 4) begin
            otherErrors++;
            $display("memory strobe at %0t ns before any instruction reached memory", $time);
        end
        if (memReq.write)
            storeQ.push_back(memReq);
    end

    initial begin
        bit got;
        clk      = 1'b0;
        reset    = 1'b1;
        instrF   = '0;
        memRdata = '0;
        loadProgram();
        loadExpected();
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        for (int i = 0; i < expectQ.size() && timeouts == 0; i++) begin
            waitForEvent(expectQ[i].isStore, got);
            if (got && expectQ[i].isStore)
                checkStore(expectQ[i].st, storeQ.pop_front());
            else if (got)
                checkRetire(expectQ[i].ret, retireQ.pop_front());
        end
        repeat (20) @(posedge clk);  // program is parked on its self jump
        if (retireQ.size() != 0 || storeQ.size() != 0) begin
            otherErrors++;
            $display("extra retire or store seen beyond the expected results");
        end
        $display("errors: %0d value, %0d timeout, %0d other", valueErrors, timeouts,
                 otherErrors);
        if (valueErrors + timeouts + otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
cpuPkg.sv
pipeReg.sv
regFile.sv
mainDecoder.sv
alu.sv
mulDivUnit.sv
hazardUnit.sv
datapath.sv
tbDatapath.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tbDatapath --Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
